//--- Bender.yml
package:
  name: upd7800_intc_timer

sources:
  - verilog/upd7800_pkg.sv
  - verilog/int_edge_sampler.sv
  - verilog/interval_timer.sv
  - verilog/int_arbiter.sv
  - verilog/upd7800_intc_timer.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_upd7800_intc_timer.sv

//--- tb.f
+incdir+test
verilog/upd7800_pkg.sv
verilog/int_edge_sampler.sv
verilog/interval_timer.sv
verilog/int_arbiter.sv
verilog/upd7800_intc_timer.sv
test/tb_upd7800_intc_timer.sv

//--- test/tb_model.svh
// Reference model of the pending, mask, fetch latch, timer and edge rules
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Model registers, advanced once per clock from the driven inputs
logic [7:0]  m_mk;
logic [3:0]  m_pending;
logic [3:0]  m_latch;
logic [11:0] m_tm;
logic [14:0] m_count;
logic [3:0]  m_hist1;
logic [3:0]  m_hist2;

// Edge needs low, high, high, high in the history, oldest first
wire       x_edge1 = cp1n && (m_hist1 == 4'b0111);
wire       x_edge2 = cp1n && (m_hist2 == 4'b0111);
wire       x_uf = cp2n && (m_count == '0);
wire       x_skit_hit = skit && m_pending[skit_idx];

// Lowest set latch bit is the source being served
wire [3:0] x_ack = m_latch & (~m_latch + 4'd1);
wire [7:0] x_vector = x_ack[0] ? 8'h04 :
                      x_ack[1] ? 8'h08 :
                      x_ack[2] ? 8'h10 :
                      x_ack[3] ? 8'h20 : 8'h60;

// Next state at the rising edge, from the inputs of this cycle
task automatic advance_model;
  logic [3:0] set_bits;
  logic [3:0] clr_bits;
  set_bits = {x_edge2, x_edge1, x_uf, int0};
  clr_bits = {3'b000, ~int0};
  if (fetch && cp2n) begin
    clr_bits = clr_bits | x_ack;
    m_latch = m_pending & ~m_mk[3:0] & {4{ie}};
  end
  if (skit && cp2n) begin
    clr_bits[skit_idx] = 1'b1;
  end
  // Set wins over clear
  m_pending = (m_pending & ~clr_bits) | set_bits;
  if (cp1n) begin
    m_hist1 = {m_hist1[2:0], int1};
    m_hist2 = {m_hist2[2:0], int2 ^ ~m_mk[5]};
  end
  // Reload is TM with three prescaler ones below it
  if (x_uf || (cp2n && stm)) begin
    m_count = {m_tm, 3'b111};
  end else if (cp2n) begin
    m_count = m_count - 15'd1;
  end
  if (spr_wr) begin
    case (spr_sel)
      SPR_MK:  m_mk = spr_wdata;
      SPR_TM0: m_tm[7:0] = spr_wdata;
      SPR_TM1: m_tm[11:8] = spr_wdata[3:0];
      default: ;
    endcase
  end
endtask

`endif

//--- test/tb_upd7800_intc_timer.sv
// Testbench with clock, LFSR stimulus, model checks, watchdog and run control

`timescale 1ns/1ps

module tb_upd7800_intc_timer;

  import upd7800_pkg::*;

  localparam int CLK_PERIOD    = 20;
  localparam int RESET_CYCLES  = 5;
  localparam int DIRECT_CYCLES = 800;
  localparam int RAND_CYCLES   = 30000;

  logic        CLK;
  logic        reset;
  logic        cp1n;
  logic        cp2n;
  logic        int0;
  logic        int1;
  logic        int2;
  logic        ie;
  logic        spr_wr;
  e_spr        spr_sel;
  logic [7:0]  spr_wdata;
  logic        fetch;
  logic        stm;
  logic        skit;
  e_int_idx    skit_idx;
  logic        int_req;
  logic [7:0]  int_vector;
  logic        skit_hit;
  logic        timer_uf;
  logic [15:0] rng;
  logic [1:0]  phase;
  int          hold;

  `include "tb_model.svh"

  upd7800_intc_timer #(.PRESCALE_BITS(3), .EDGE_SAMPLES(3)) DUT (.*);

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // Watchdog sized from the cycle counts of the test
  initial begin
    #((RESET_CYCLES + DIRECT_CYCLES + RAND_CYCLES + 500) * CLK_PERIOD);
    $display("Timeout: the test did not complete within the expected number of cycles");
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

  // 16-bit Galois LFSR, taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      rng = lfsr_next(rng);
      v[i] = rng[0];
    end
  endtask

  task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("Simulation failed");
      $fatal(1, "output mismatch");
    end
  endtask

  // One clock with the CP strobes, outputs checked ahead of the rising edge
  task automatic run_cycle;
    cp1n = (phase == 2'd0);
    cp2n = (phase == 2'd2);
    phase = phase + 2'd1;
    #(CLK_PERIOD / 4);
    check_value("int_req", int_req, |m_latch);
    check_value("int_vector", int_vector, x_vector);
    check_value("skit_hit", skit_hit, x_skit_hit);
    check_value("timer_uf", timer_uf, x_uf);
    advance_model();
    @(negedge CLK);
  endtask

  task automatic write_spr(input e_spr sel, input logic [7:0] data);
    spr_wr = 1'b1;
    spr_sel = sel;
    spr_wdata = data;
    run_cycle();
    spr_wr = 1'b0;
  endtask

  task automatic random_inputs;
    logic [15:0] v;
    // INT1 and INT2 stay put for whole CP1 periods
    if (hold == 0) begin
      draw_bits(6, v);
      {int2, int1} = v[1:0];
      hold = 4 * (v[5:2] + 1);
    end
    hold--;
    draw_bits(14, v);
    int0 = v[0];
    ie = |v[2:1];
    fetch = v[3];
    skit = (v[5:4] == 2'd0);
    skit_idx = e_int_idx'(v[7:6]);
    spr_wr = (v[11:8] == 4'd0);
    spr_sel = e_spr'(v[13:12]);
    draw_bits(16, v);
    stm = (v[15:8] == 8'd0);
    // Small TM keeps underflows frequent
    spr_wdata = v[7:0] & (spr_sel == SPR_TM1 ? 8'hf0 : spr_sel == SPR_TM0 ? 8'h1f : 8'hff);
  endtask

  initial begin
    reset = 1'b1;
    {cp1n, cp2n, int0, int1, int2, ie, spr_wr, fetch, stm, skit} = '0;
    spr_sel = SPR_NONE;
    spr_wdata = '0;
    skit_idx = II_INT0;
    rng = 16'd61956;
    phase = '0;
    hold = 0;
    // Model starts in the reset state
    m_mk = 8'hff;
    {m_pending, m_latch, m_hist1, m_hist2} = '0;
    {m_tm, m_count} = '1;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    reset = 1'b0;

    // Reset values, then TM = 5 with STM restarts
    repeat (8) run_cycle();
    write_spr(SPR_TM0, 8'h05);
    write_spr(SPR_TM1, 8'hf0);
    repeat (2) begin
      stm = 1'b1;
      repeat (4) run_cycle();
      stm = 1'b0;
      repeat (300) run_cycle();
    end

    // INT1 edge, fetch and acknowledge, INT2 active low, SKIT, then INT2 inverted
    write_spr(SPR_MK, 8'h00);
    ie = 1'b1;
    int2 = 1'b1;
    repeat (16) run_cycle();
    int1 = 1'b1;
    repeat (16) run_cycle();
    fetch = 1'b1;
    int2 = 1'b0;
    repeat (20) run_cycle();
    fetch = 1'b0;
    skit = 1'b1;
    skit_idx = II_INT2;
    repeat (4) run_cycle();
    skit = 1'b0;
    write_spr(SPR_MK, 8'h20);
    repeat (16) run_cycle();
    int2 = 1'b1;
    repeat (16) run_cycle();

    repeat (RAND_CYCLES) begin
      random_inputs();
      run_cycle();
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- verilog/int_arbiter.sv
// MK register, pending flags, fetch latch, priority encoder, vector, SKIT test

`timescale 1ns/1ps

module int_arbiter (
  input  logic                           CLK,
  input  logic                           reset,
  input  logic                           cp2n,
  input  logic                           ie,
  input  logic                           int0,
  input  logic                           int1_edge,
  input  logic                           int2_edge,
  input  logic                           timer_uf,
  input  logic                           fetch,
  input  logic                           skit,
  input  upd7800_pkg::e_int_idx          skit_idx,
  input  logic                           spr_wr,
  input  upd7800_pkg::e_spr              spr_sel,
  input  logic [upd7800_pkg::DATA_W-1:0] spr_wdata,
  output logic                           int2_pol,
  output logic                           int_req,
  output logic                           skit_hit,
  output logic [7:0]                     int_vector
);

  import upd7800_pkg::*;

  logic [DATA_W-1:0]  mk;
  logic [NUM_INT-1:0] pending;
  logic [NUM_INT-1:0] pend_set;
  logic [NUM_INT-1:0] pend_clr;
  logic [NUM_INT-1:0] enabled;
  logic [NUM_INT-1:0] int_latch;
  logic [NUM_INT-1:0] ack;
  e_int_idx           ack_idx;
  logic               fetch_go;
  logic               skit_go;

  assign fetch_go = fetch & cp2n;
  assign skit_go  = skit & cp2n;

  //////////////////////////////////////////////////////////////////////
  // Mask register

  always_ff @(posedge CLK) begin
    if (reset) begin
      mk <= MK_RESET;
    end else if (spr_wr && spr_sel == SPR_MK) begin
      mk <= spr_wdata;
    end
  end

  assign int2_pol = mk[MK_INT2_POL];

  //////////////////////////////////////////////////////////////////////
  // Pending flags

  always_comb begin
    pend_set = '0;
    pend_set[II_INT0] = int0;
    pend_set[II_INTT] = timer_uf;
    pend_set[II_INT1] = int1_edge;
    pend_set[II_INT2] = int2_edge;
  end

  // INT0 is level sensitive, so it also drops with the pin
  always_comb begin
    pend_clr = '0;
    pend_clr[II_INT0] = ~int0;
    if (fetch_go && int_req) begin
      pend_clr = pend_clr | ack;
    end
    if (skit_go) begin
      pend_clr[skit_idx] = 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~pend_clr) | pend_set;
    end
  end

  // Test half of SKIT, the clear happens above
  assign skit_hit = skit & pending[skit_idx];

  //////////////////////////////////////////////////////////////////////
  // Fetch latch and priority

  // Mask bit n gates source n
  assign enabled = {NUM_INT{ie}} & ~mk[NUM_INT-1:0];

  always_ff @(posedge CLK) begin
    if (reset) begin
      int_latch <= '0;
    end else if (fetch_go) begin
      int_latch <= pending & enabled;
    end
  end

  assign int_req = |int_latch;

  // Lowest index wins
  always_comb begin
    ack_idx = II_INT0;
    for (int i = NUM_INT - 1; i >= 0; i--) begin
      if (int_latch[i]) begin
        ack_idx = e_int_idx'(i);
      end
    end
  end

  always_comb begin
    ack = '0;
    if (int_req) begin
      ack[ack_idx] = 1'b1;
    end
  end

  assign int_vector = int_req ? vector_of(ack_idx) : VEC_SOFTI;

  // A fetch taken with interrupts disabled latches nothing
  a_latch_needs_ie: assert property (
    @(posedge CLK) disable iff (reset)
    (fetch_go && !ie) |=> (int_latch == '0)
  ) else $error("request latched while ie was low");

endmodule

//--- verilog/int_edge_sampler.sv
// INT1/INT2 sampling on CP1 falling and qualified edge detection

`timescale 1ns/1ps

module int_edge_sampler #(
  parameter int EDGE_SAMPLES = 3
) (
  input  logic CLK,
  input  logic reset,
  input  logic cp1n,
  input  logic int1,
  input  logic int2,
  input  logic int2_pol,
  output logic int1_edge,
  output logic int2_edge
);

  // One low sample followed by EDGE_SAMPLES high ones, oldest in the MSB
  localparam logic [EDGE_SAMPLES:0] EDGE_PATTERN = {1'b0, {EDGE_SAMPLES{1'b1}}};

  // Index 0 is INT1, index 1 is INT2
  logic [EDGE_SAMPLES:0] hist [2];
  logic [1:0]            sample_in;
  logic [1:0]            edge_hit;

  //////////////////////////////////////////////////////////////////////
  // Sampling

  // INT2 counts as active low unless MK bit 5 is set
  always_comb begin
    sample_in[0] = int1;
    sample_in[1] = int2 ^ ~int2_pol;
  end

  always_ff @(posedge CLK) begin
    for (int i = 0; i < 2; i++) begin
      if (reset) begin
        hist[i] <= '0;
      end else if (cp1n) begin
        hist[i] <= {hist[i][EDGE_SAMPLES-1:0], sample_in[i]};
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Edge detection

  // Checked against the history before this strobe shifts it
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      edge_hit[i] = cp1n & (hist[i] == EDGE_PATTERN);
    end
  end

  assign int1_edge = edge_hit[0];
  assign int2_edge = edge_hit[1];

  // A pulse shifts a high sample in and blocks a match on the next strobe
  a_edge_once: assert property (
    @(posedge CLK) disable iff (reset)
    !(int1_edge && $past(int1_edge)) && !(int2_edge && $past(int2_edge))
  ) else $error("edge pulse repeated without a new low sample");

endmodule

//--- verilog/interval_timer.sv
// TM0/TM1 reload registers, prescaled 12-bit down counter, underflow pulse

`timescale 1ns/1ps

module interval_timer #(
  parameter int PRESCALE_BITS = 3
) (
  input  logic                           CLK,
  input  logic                           reset,
  input  logic                           cp2n,
  input  logic                           stm,
  input  logic                           spr_wr,
  input  upd7800_pkg::e_spr              spr_sel,
  input  logic [upd7800_pkg::DATA_W-1:0] spr_wdata,
  output logic                           timer_uf
);

  import upd7800_pkg::*;

  // Prescaler sits in the low bits of one combined counter
  localparam int CNT_W = TM_W + PRESCALE_BITS;

  logic [TM_W-1:0]  tm;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] reload_val;
  logic             reload;

  //////////////////////////////////////////////////////////////////////
  // Reload registers

  // TM0 is the low byte, TM1 supplies the top nibble
  always_ff @(posedge CLK) begin
    if (reset) begin
      tm <= '1;
    end else if (spr_wr) begin
      case (spr_sel)
        SPR_TM0: tm[DATA_W-1:0] <= spr_wdata;
        SPR_TM1: tm[TM_W-1:DATA_W] <= spr_wdata[TM_W-DATA_W-1:0];
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Down counter

  // Prescaler restarts full on every reload
  assign reload_val = {tm, {PRESCALE_BITS{1'b1}}};

  assign timer_uf = cp2n & (count == '0);

  // STM restarts the count but raises no interrupt
  assign reload = timer_uf | (cp2n & stm);

  always_ff @(posedge CLK) begin
    if (reset) begin
      count <= '1;
    end else if (reload) begin
      count <= reload_val;
    end else if (cp2n) begin
      count <= count - 1'b1;
    end
  end

  // Prescaler ones leave the reloaded count nonzero for the next strobe
  a_uf_spacing: assert property (
    @(posedge CLK) disable iff (reset)
    timer_uf |=> !timer_uf
  ) else $error("underflow on two cycles in a row");

endmodule

//--- verilog/upd7800_intc_timer.sv
// Top level joining the edge sampler, interval timer and interrupt arbiter

`timescale 1ns/1ps

module upd7800_intc_timer #(
  parameter int PRESCALE_BITS = 3,
  parameter int EDGE_SAMPLES  = 3
) (
  input  logic                           CLK,
  input  logic                           reset,
  input  logic                           cp1n,
  input  logic                           cp2n,
  input  logic                           int0,
  input  logic                           int1,
  input  logic                           int2,
  input  logic                           ie,
  input  logic                           spr_wr,
  input  upd7800_pkg::e_spr              spr_sel,
  input  logic [upd7800_pkg::DATA_W-1:0] spr_wdata,
  input  logic                           fetch,
  input  logic                           stm,
  input  logic                           skit,
  input  upd7800_pkg::e_int_idx          skit_idx,
  output logic                           int_req,
  output logic [7:0]                     int_vector,
  output logic                           skit_hit,
  output logic                           timer_uf
);

  logic int2_pol;
  logic int1_edge;
  logic int2_edge;

  //////////////////////////////////////////////////////////////////////
  // Edge-triggered inputs

  int_edge_sampler #(
    .EDGE_SAMPLES (EDGE_SAMPLES)
  ) u_sampler (
    .CLK       (CLK),
    .reset     (reset),
    .cp1n      (cp1n),
    .int1      (int1),
    .int2      (int2),
    .int2_pol  (int2_pol),
    .int1_edge (int1_edge),
    .int2_edge (int2_edge)
  );

  //////////////////////////////////////////////////////////////////////
  // Timer

  interval_timer #(
    .PRESCALE_BITS (PRESCALE_BITS)
  ) u_timer (
    .CLK       (CLK),
    .reset     (reset),
    .cp2n      (cp2n),
    .stm       (stm),
    .spr_wr    (spr_wr),
    .spr_sel   (spr_sel),
    .spr_wdata (spr_wdata),
    .timer_uf  (timer_uf)
  );

  //////////////////////////////////////////////////////////////////////
  // Arbitration

  int_arbiter u_arbiter (
    .CLK        (CLK),
    .reset      (reset),
    .cp2n       (cp2n),
    .ie         (ie),
    .int0       (int0),
    .int1_edge  (int1_edge),
    .int2_edge  (int2_edge),
    .timer_uf   (timer_uf),
    .fetch      (fetch),
    .skit       (skit),
    .skit_idx   (skit_idx),
    .spr_wr     (spr_wr),
    .spr_sel    (spr_sel),
    .spr_wdata  (spr_wdata),
    .int2_pol   (int2_pol),
    .int_req    (int_req),
    .skit_hit   (skit_hit),
    .int_vector (int_vector)
  );

endmodule

//--- verilog/upd7800_pkg.sv
// Shared widths, interrupt index and special-register enums, vector constants

package upd7800_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths

  // Special-register write data
  localparam int DATA_W = 8;

  // Timer reload value, TM1[3:0] and TM0[7:0]
  localparam int TM_W = 12;

  // Interrupt sources kept in this block
  localparam int NUM_INT = 4;

  //////////////////////////////////////////////////////////////////////
  // Enums

  // Interrupt sources, highest priority first
  typedef enum logic [1:0] {
    II_INT0 = 2'd0,
    II_INTT = 2'd1,
    II_INT1 = 2'd2,
    II_INT2 = 2'd3
  } e_int_idx;

  // Special-register write targets
  typedef enum logic [1:0] {
    SPR_NONE = 2'd0,
    SPR_MK   = 2'd1,
    SPR_TM0  = 2'd2,
    SPR_TM1  = 2'd3
  } e_spr;

  //////////////////////////////////////////////////////////////////////
  // Vectors and mask constants

  localparam logic [7:0] VEC_INT0  = 8'h04;
  localparam logic [7:0] VEC_INTT  = 8'h08;
  localparam logic [7:0] VEC_INT1  = 8'h10;
  localparam logic [7:0] VEC_INT2  = 8'h20;
  // Reported when no source won the fetch
  localparam logic [7:0] VEC_SOFTI = 8'h60;

  // MK bit that flips the INT2 sense
  localparam int MK_INT2_POL = 5;

  // Everything masked out of reset
  localparam logic [DATA_W-1:0] MK_RESET = 8'hff;

  // Vector address of one source
  function automatic logic [7:0] vector_of(e_int_idx idx);
    case (idx)
      II_INT0: return VEC_INT0;
      II_INTT: return VEC_INTT;
      II_INT1: return VEC_INT1;
      II_INT2: return VEC_INT2;
      default: return VEC_SOFTI;
    endcase
  endfunction

endpackage
